//--- hazard_unit.f
+incdir+hw
hw/rv32i_types.sv
hw/stage_tracker.sv
hw/hazard_detector.sv
hw/forwarder.sv
hw/operand_select.sv
hw/hazard_unit.sv
test/tb_clock.sv
test/tb_hazard_unit.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       := tb_hazard_unit
FLIST     := hazard_unit.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(filter-out +%,$(shell cat $(FLIST))) $(wildcard hw/*.svh)
PASS_MSG  := Simulation completed successfully

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_hazard_unit.sv
`timescale 1ns/100ps

module tb_hazard_unit;
    import rv32i_types::*;

    localparam int unsigned SEED = 32'hfb34_60a4;
    localparam int NUM_TESTS = 5;
    // longest test is the branch one, about 40 cycles
    localparam int CYCLES_PER_TEST = 50;
    localparam int RUN_CYCLES = 5 + NUM_TESTS * CYCLES_PER_TEST + 20;

    logic         clk;
    logic         rst;
    logic         instr_valid;
    rv32i_instr_t instr;
    stage_data_t  stage_data;
    fwd_sel_t     fwd_sel;
    operands_t    operands;
    logic         stall;

    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int tests_bad = 0;

    tb_clock #(.PERIOD_NS(10)) u_clock (.clk_o(clk));

    hazard_unit dut_i (
        .clk_i         (clk),
        .rst_i         (rst),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .stage_data_i  (stage_data),
        .fwd_sel_o     (fwd_sel),
        .operands_o    (operands),
        .stall_o       (stall)
    );

    // ********************
    // stimulus helpers
    // ********************
    function automatic rv32i_instr_t r_instr(rv32i_opcode op, rv32i_reg rd,
                                             rv32i_reg rs1, rv32i_reg rs2);
        rv32i_instr_t w;
        w = '0;
        w.r.opcode = op;
        w.r.rd     = rd;
        w.r.rs1    = rs1;
        w.r.rs2    = rs2;
        return w;
    endfunction

    function automatic rv32i_instr_t u_instr(rv32i_opcode op, rv32i_reg rd,
                                             logic [19:0] imm);
        rv32i_instr_t w;
        w.u.opcode = op;
        w.u.rd     = rd;
        w.u.imm    = imm;
        return w;
    endfunction

    function automatic stage_data_t random_data();
        stage_data_t v;
        v.id_ex_rs1   = $urandom;
        v.id_ex_rs2   = $urandom;
        v.ex_mem_rs2  = $urandom;
        v.regfile_rs1 = $urandom;
        v.regfile_rs2 = $urandom;
        v.ex_result   = $urandom;
        v.mem_alu     = $urandom;
        v.mem_ld      = $urandom;
        v.wb_data     = $urandom;
        return v;
    endfunction

    // put one instruction in decode for the coming cycle
    task automatic present(rv32i_instr_t w);
        @(posedge clk);
        instr       <= w;
        instr_valid <= 1'b1;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        instr       <= '0;
        instr_valid <= 1'b0;
    endtask

    // four empty cycles flush decode and all three stages, fresh data too
    task automatic clear_pipe();
        @(posedge clk);
        stage_data <= random_data();
        instr       <= '0;
        instr_valid <= 1'b0;
        repeat (3) idle_cycle();
    endtask

    // ********************
    // expected values
    // ********************
    function automatic fwd_sel_t fwd_want(forwarding1_sel_t a, forwarding1_sel_t b,
                                          forwarding2_sel_t c, forwarding3_sel_t d,
                                          forwarding3_sel_t e);
        fwd_sel_t s;
        s.a = a;
        s.b = b;
        s.c = c;
        s.d = d;
        s.e = e;
        return s;
    endfunction

    // operands with no forwarding at all
    function automatic operands_t base_ops(stage_data_t v);
        operands_t o;
        o.alu_a      = v.id_ex_rs1;
        o.alu_b      = v.id_ex_rs2;
        o.store_data = v.ex_mem_rs2;
        o.branch_a   = v.regfile_rs1;
        o.branch_b   = v.regfile_rs2;
        return o;
    endfunction

    // ********************
    // compare tasks
    // ********************
    task automatic compare_sel(fwd_sel_t want);
        checks++;
        if (fwd_sel !== want) begin
            errors++;
            $display("[FAIL] fwd_sel_o got 0x%h expected 0x%h", fwd_sel, want);
        end
    endtask

    task automatic match_ops(operands_t want);
        checks++;
        if (operands !== want) begin
            errors++;
            $display("[FAIL] operands_o got 0x%h expected 0x%h", operands, want);
        end
    endtask

    task automatic stall_is(logic want);
        checks++;
        if (stall !== want) begin
            errors++;
            $display("[FAIL] stall_o got 0x%h expected 0x%h", stall, want);
        end
    endtask

    task automatic report_test(string name, int start_errs);
        tests_run++;
        if (errors == start_errs) begin
            $display("test %s passed", name);
        end else begin
            tests_bad++;
            $display("test %s had %0d errors", name, errors - start_errs);
        end
    endtask

    // ********************
    // directed tests
    // ********************
    task automatic after_reset();
        int start_errs;
        start_errs = errors;
        @(negedge clk);
        stall_is(1'b0);
        compare_sel(fwd_want(id_ex, id_ex, mem, id, id));
        match_ops(base_ops(stage_data));
        report_test("after_reset", start_errs);
    endtask

    task automatic alu_forwarding();
        int start_errs;
        operands_t want;
        start_errs = errors;
        // reader right behind producer, both operands from ex/mem
        clear_pipe();
        present(r_instr(op_reg, 5, 1, 2));
        present(r_instr(op_reg, 6, 5, 5));
        idle_cycle();
        @(negedge clk);
        compare_sel(fwd_want(ex_mem, ex_mem, mem, id, id));
        want = base_ops(stage_data);
        want.alu_a = stage_data.mem_alu;
        want.alu_b = stage_data.mem_alu;
        match_ops(want);
        // one gap, rs1 from mem/wb
        clear_pipe();
        present(r_instr(op_reg, 5, 1, 2));
        idle_cycle();
        present(r_instr(op_reg, 6, 5, 3));
        idle_cycle();
        @(negedge clk);
        compare_sel(fwd_want(mem_wb, id_ex, mem, id, id));
        want = base_ops(stage_data);
        want.alu_a = stage_data.wb_data;
        match_ops(want);
        // x5 written twice, the newer ex/mem copy wins
        clear_pipe();
        present(r_instr(op_reg, 5, 1, 2));
        present(r_instr(op_reg, 5, 3, 4));
        present(r_instr(op_reg, 6, 5, 5));
        idle_cycle();
        @(negedge clk);
        compare_sel(fwd_want(ex_mem, ex_mem, mem, id, id));
        want = base_ops(stage_data);
        want.alu_a = stage_data.mem_alu;
        want.alu_b = stage_data.mem_alu;
        match_ops(want);
        // lui x7, read on rs2 one cycle on, on rs1 two cycles on
        clear_pipe();
        present(u_instr(op_lui, 7, 20'habcde));
        present(r_instr(op_reg, 8, 0, 7));
        present(r_instr(op_reg, 9, 7, 0));
        @(negedge clk);
        // the second reader in decode sees lui in mem as a plain alu value
        compare_sel(fwd_want(id_ex, u_imm_ex_mem, mem, mem_alu, id));
        want = base_ops(stage_data);
        want.alu_b    = 32'habcde000;
        want.branch_a = stage_data.mem_alu;
        match_ops(want);
        idle_cycle();
        @(negedge clk);
        compare_sel(fwd_want(u_imm_mem_wb, id_ex, mem, id, id));
        want = base_ops(stage_data);
        want.alu_a = 32'habcde000;
        match_ops(want);
        report_test("alu_forwarding", start_errs);
    endtask

    task automatic load_use_stall();
        int start_errs;
        operands_t want;
        start_errs = errors;
        clear_pipe();
        present(r_instr(op_load, 6, 1, 0));
        present(r_instr(op_reg, 8, 6, 2));
        @(negedge clk);
        stall_is(1'b1);
        // same reader again while the bubble goes into ex
        present(r_instr(op_reg, 8, 6, 2));
        @(negedge clk);
        stall_is(1'b0);
        idle_cycle();
        @(negedge clk);
        stall_is(1'b0);
        compare_sel(fwd_want(mem_wb, id_ex, mem, id, id));
        want = base_ops(stage_data);
        want.alu_a = stage_data.wb_data;
        match_ops(want);
        report_test("load_use_stall", start_errs);
    endtask

    task automatic load_then_store();
        int start_errs;
        operands_t want;
        start_errs = errors;
        clear_pipe();
        present(r_instr(op_load, 9, 1, 0));
        present(r_instr(op_store, 0, 3, 9));
        @(negedge clk);
        stall_is(1'b1);
        present(r_instr(op_store, 0, 3, 9));
        @(negedge clk);
        stall_is(1'b0);
        // stall leaves the store one stage further back, rs2 comes over b
        idle_cycle();
        @(negedge clk);
        compare_sel(fwd_want(id_ex, mem_wb, mem, id, id));
        want = base_ops(stage_data);
        want.alu_b = stage_data.wb_data;
        match_ops(want);
        // load retired by the time the store is in mem
        idle_cycle();
        @(negedge clk);
        compare_sel(fwd_want(id_ex, id_ex, mem, id, id));
        match_ops(base_ops(stage_data));
        report_test("load_then_store", start_errs);
    endtask

    task automatic branch_forwarding();
        int start_errs;
        operands_t want;
        start_errs = errors;
        // write to x0 is never forwarded
        clear_pipe();
        present(r_instr(op_imm, 0, 1, 0));
        present(r_instr(op_br, 0, 0, 0));
        @(negedge clk);
        compare_sel(fwd_want(id_ex, id_ex, mem, id, id));
        match_ops(base_ops(stage_data));
        // ex beats mem
        clear_pipe();
        present(r_instr(op_imm, 13, 0, 0));
        present(r_instr(op_imm, 13, 0, 0));
        present(r_instr(op_br, 0, 13, 0));
        @(negedge clk);
        compare_sel(fwd_want(id_ex, id_ex, mem, ex, id));
        want = base_ops(stage_data);
        want.branch_a = stage_data.ex_result;
        match_ops(want);
        // mem beats wb
        clear_pipe();
        present(r_instr(op_imm, 13, 0, 0));
        present(r_instr(op_imm, 13, 0, 0));
        idle_cycle();
        present(r_instr(op_br, 0, 13, 13));
        @(negedge clk);
        compare_sel(fwd_want(id_ex, id_ex, mem, mem_alu, mem_alu));
        want = base_ops(stage_data);
        want.branch_a = stage_data.mem_alu;
        want.branch_b = stage_data.mem_alu;
        match_ops(want);
        // load in mem, alu in ex
        clear_pipe();
        present(r_instr(op_load, 10, 1, 0));
        present(r_instr(op_imm, 11, 0, 0));
        present(r_instr(op_br, 0, 10, 11));
        @(negedge clk);
        stall_is(1'b0);
        compare_sel(fwd_want(id_ex, id_ex, mem, mem_ld, ex));
        want = base_ops(stage_data);
        want.branch_a = stage_data.mem_ld;
        want.branch_b = stage_data.ex_result;
        match_ops(want);
        // load in wb, alu in mem
        clear_pipe();
        present(r_instr(op_load, 10, 1, 0));
        present(r_instr(op_imm, 11, 0, 0));
        idle_cycle();
        present(r_instr(op_br, 0, 10, 11));
        @(negedge clk);
        compare_sel(fwd_want(id_ex, id_ex, mem, wb_ld, mem_alu));
        want = base_ops(stage_data);
        want.branch_a = stage_data.wb_data;
        want.branch_b = stage_data.mem_alu;
        match_ops(want);
        // alu result in wb
        clear_pipe();
        present(r_instr(op_imm, 14, 0, 0));
        idle_cycle();
        idle_cycle();
        present(r_instr(op_br, 0, 14, 0));
        @(negedge clk);
        compare_sel(fwd_want(id_ex, id_ex, mem, wb_alu, id));
        want = base_ops(stage_data);
        want.branch_a = stage_data.wb_data;
        match_ops(want);
        report_test("branch_forwarding", start_errs);
    endtask

    // ********************
    // run control
    // ********************
    initial begin
        #(RUN_CYCLES * 10);
        $display("watchdog timeout, run did not finish within %0d cycles", RUN_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        stage_data  = random_data();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        after_reset();
        alu_forwarding();
        load_use_stall();
        load_then_store();
        branch_forwarding();
        $display("tests %0d, failing tests %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD_NS = 10
) (
    output logic clk_o
);
    // free running, first rising edge at half a period
    initial clk_o = 1'b0;
    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

//--- hw/hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      instr_valid_i,
    input  rv32i_types::rv32i_instr_t instr_i,
    input  rv32i_types::stage_data_t  stage_data_i,
    output rv32i_types::fwd_sel_t     fwd_sel_o,
    output rv32i_types::operands_t    operands_o,
    output logic                      stall_o
);
    import rv32i_types::*;

    // tracked stage state
    stage_info_t dec_info;
    stage_info_t id_ex_info;
    stage_info_t ex_mem_info;
    stage_info_t mem_wb_info;

    // ********************
    // pipeline tracking
    // ********************
    stage_tracker u_tracker (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .stall_i       (stall_o),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .dec_info_o    (dec_info),
        .id_ex_o       (id_ex_info),
        .ex_mem_o      (ex_mem_info),
        .mem_wb_o      (mem_wb_info)
    );

    // load-use stall
    hazard_detector u_detector (
        .dec_info_i (dec_info),
        .id_ex_i    (id_ex_info),
        .stall_o    (stall_o)
    );

    // ********************
    // forwarding
    // ********************
    forwarder u_forwarder (
        .dec_info_i (dec_info),
        .id_ex_i    (id_ex_info),
        .ex_mem_i   (ex_mem_info),
        .mem_wb_i   (mem_wb_info),
        .fwd_sel_o  (fwd_sel_o)
    );

    // selects applied to datapath values
    operand_select u_operand_select (
        .fwd_sel_i      (fwd_sel_o),
        .stage_data_i   (stage_data_i),
        .ex_mem_u_imm_i (ex_mem_info.u_imm),
        .mem_wb_u_imm_i (mem_wb_info.u_imm),
        .operands_o     (operands_o)
    );

endmodule

//--- hw/operand_select.sv
`timescale 1ns/100ps

module operand_select (
    input  rv32i_types::fwd_sel_t    fwd_sel_i,
    input  rv32i_types::stage_data_t stage_data_i,
    input  rv32i_types::rv32i_word   ex_mem_u_imm_i,
    input  rv32i_types::rv32i_word   mem_wb_u_imm_i,
    output rv32i_types::operands_t   operands_o
);
    import rv32i_types::*;

    // alu operand mux falling back to the id/ex register value
    function automatic rv32i_word alu_mux(forwarding1_sel_t sel, rv32i_word base);
        case (sel)
            ex_mem:       return stage_data_i.mem_alu;
            mem_wb:       return stage_data_i.wb_data;
            u_imm_ex_mem: return ex_mem_u_imm_i;
            u_imm_mem_wb: return mem_wb_u_imm_i;
            default:      return base;
        endcase
    endfunction

    // branch compare mux falling back to the regfile read
    function automatic rv32i_word br_mux(forwarding3_sel_t sel, rv32i_word base);
        case (sel)
            ex:      return stage_data_i.ex_result;
            mem_alu: return stage_data_i.mem_alu;
            mem_ld:  return stage_data_i.mem_ld;
            // writeback value already muxed between alu and load
            wb_alu, wb_ld: return stage_data_i.wb_data;
            default: return base;
        endcase
    endfunction

    // ********************
    // operand muxes
    // ********************
    always_comb begin
        operands_o.alu_a = alu_mux(fwd_sel_i.a, stage_data_i.id_ex_rs1);
        operands_o.alu_b = alu_mux(fwd_sel_i.b, stage_data_i.id_ex_rs2);
        case (fwd_sel_i.c)
            wb:      operands_o.store_data = stage_data_i.wb_data;
            default: operands_o.store_data = stage_data_i.ex_mem_rs2;
        endcase
        operands_o.branch_a = br_mux(fwd_sel_i.d, stage_data_i.regfile_rs1);
        operands_o.branch_b = br_mux(fwd_sel_i.e, stage_data_i.regfile_rs2);
    end

endmodule

//--- hw/forwarder.sv
`timescale 1ns/100ps

module forwarder (
    input  rv32i_types::stage_info_t dec_info_i,
    input  rv32i_types::stage_info_t id_ex_i,
    input  rv32i_types::stage_info_t ex_mem_i,
    input  rv32i_types::stage_info_t mem_wb_i,
    output rv32i_types::fwd_sel_t    fwd_sel_o
);
    import rv32i_types::*;

    logic store_hazard;

    // producer writes a nonzero rd equal to a nonzero source
    function automatic logic hits(stage_info_t prod, rv32i_reg src);
        return prod.ctrl.load_regfile
             & (prod.rd != '0)
             & (src != '0)
             & (prod.rd == src);
    endfunction

    // ********************
    // alu operands
    // ********************
    // near is ex/mem, far is mem/wb
    // lui results come from the carried immediate
    function automatic forwarding1_sel_t alu_src_sel(
        rv32i_reg    src,
        stage_info_t near,
        stage_info_t far
    );
        if (hits(near, src)) begin
            if (near.ctrl.regfilemux_sel == u_imm) begin
                return u_imm_ex_mem;
            end
            return ex_mem;
        end
        if (hits(far, src)) begin
            if (far.ctrl.regfilemux_sel == u_imm) begin
                return u_imm_mem_wb;
            end
            return mem_wb;
        end
        return id_ex;
    endfunction

    // ********************
    // branch compare
    // ********************
    // priority ex, then mem, then wb
    // load vs alu picks which mem/wb value to use
    function automatic forwarding3_sel_t br_src_sel(
        rv32i_reg    src,
        stage_info_t ex_st,
        stage_info_t mem_st,
        stage_info_t wb_st
    );
        if (hits(ex_st, src)) begin
            return ex;
        end
        if (hits(mem_st, src)) begin
            if (mem_st.ctrl.opcode == op_load) begin
                return mem_ld;
            end
            return mem_alu;
        end
        if (hits(wb_st, src)) begin
            if (wb_st.ctrl.opcode == op_load) begin
                return wb_ld;
            end
            return wb_alu;
        end
        return id;
    endfunction

    // ********************
    // store data
    // ********************
    // load in wb feeding the rs2 of a store in mem
    assign store_hazard = hits(mem_wb_i, ex_mem_i.rs2)
                        & (mem_wb_i.ctrl.opcode == op_load)
                        & (ex_mem_i.ctrl.opcode == op_store);

    always_comb begin
        fwd_sel_o.a = alu_src_sel(id_ex_i.rs1, ex_mem_i, mem_wb_i);
        fwd_sel_o.b = alu_src_sel(id_ex_i.rs2, ex_mem_i, mem_wb_i);
        if (store_hazard) begin
            fwd_sel_o.c = wb;
        end else begin
            fwd_sel_o.c = mem;
        end
        // decode sources against every later stage
        fwd_sel_o.d = br_src_sel(dec_info_i.rs1, id_ex_i, ex_mem_i, mem_wb_i);
        fwd_sel_o.e = br_src_sel(dec_info_i.rs2, id_ex_i, ex_mem_i, mem_wb_i);
    end

endmodule

//--- hw/hazard_detector.sv
`timescale 1ns/100ps

module hazard_detector (
    input  rv32i_types::stage_info_t dec_info_i,
    input  rv32i_types::stage_info_t id_ex_i,
    output logic                     stall_o
);
    import rv32i_types::*;

    logic load_in_ex;
    logic rs1_dep;
    logic rs2_dep;

    // load in ex that actually writes a register
    assign load_in_ex = id_ex_i.ctrl.load_regfile
                      & (id_ex_i.ctrl.opcode == op_load)
                      & (id_ex_i.rd != '0);

    // dec_info is all zero when decode holds no valid instruction
    assign rs1_dep = (dec_info_i.rs1 != '0) & (dec_info_i.rs1 == id_ex_i.rd);
    assign rs2_dep = (dec_info_i.rs2 != '0) & (dec_info_i.rs2 == id_ex_i.rd);

    // load data only exists after mem, so hold decode one cycle
    // the bubble in id_ex drops the stall on the next cycle
    assign stall_o = load_in_ex & (rs1_dep | rs2_dep);

endmodule

//--- hw/stage_tracker.sv
`timescale 1ns/100ps
`include "hazard_cfg.svh"

module stage_tracker (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      stall_i,
    input  logic                      instr_valid_i,
    input  rv32i_types::rv32i_instr_t instr_i,
    output rv32i_types::stage_info_t  dec_info_o,
    output rv32i_types::stage_info_t  id_ex_o,
    output rv32i_types::stage_info_t  ex_mem_o,
    output rv32i_types::stage_info_t  mem_wb_o
);
    import rv32i_types::*;

    rv32i_opcode     opc;
    logic            use_rs1;
    logic            use_rs2;
    logic            writes;
    regfilemux_sel_t wb_sel;

    assign opc = rv32i_opcode'(instr_i.r.opcode);

    // ********************
    // decode
    // ********************
    // which fields the format really carries
    always_comb begin
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        writes  = 1'b0;
        wb_sel  = alu_out;
        case (opc)
            op_lui: begin
                writes = 1'b1;
                wb_sel = u_imm;
            end
            op_auipc, op_jal: writes = 1'b1;
            op_jalr, op_imm: begin
                writes  = 1'b1;
                use_rs1 = 1'b1;
            end
            op_load: begin
                writes  = 1'b1;
                use_rs1 = 1'b1;
                wb_sel  = mem_rdata;
            end
            op_reg: begin
                writes  = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            op_br, op_store: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            // unknown opcode, treat as a nop
            default: ;
        endcase
    end

    // unused fields forced to zero so they never match
    always_comb begin
        dec_info_o = '0;
        if (instr_valid_i) begin
            dec_info_o.rs1                 = use_rs1 ? instr_i.r.rs1 : '0;
            dec_info_o.rs2                 = use_rs2 ? instr_i.r.rs2 : '0;
            dec_info_o.rd                  = writes ? instr_i.r.rd : '0;
            dec_info_o.ctrl.opcode         = opc;
            dec_info_o.ctrl.regfilemux_sel = wb_sel;
            dec_info_o.ctrl.load_regfile   = writes;
            // u immediate sits in the upper 20 bits
            if (opc == op_lui || opc == op_auipc) begin
                dec_info_o.u_imm = {instr_i.u.imm, {(`HAZ_XLEN-20){1'b0}}};
            end
        end
    end

    // ********************
    // stage registers
    // ********************
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            id_ex_o  <= '0;
            ex_mem_o <= '0;
            mem_wb_o <= '0;
        end else begin
            // bubble into ex while decode waits
            if (stall_i) begin
                id_ex_o <= '0;
            end else begin
                id_ex_o <= dec_info_o;
            end
            ex_mem_o <= id_ex_o;
            mem_wb_o <= ex_mem_o;
        end
    end

endmodule

//--- hw/rv32i_types.sv
`include "hazard_cfg.svh"

package rv32i_types;

    // ********************
    // basic words
    // ********************
    typedef logic [`HAZ_XLEN-1:0] rv32i_word;
    typedef logic [`HAZ_REG_W-1:0] rv32i_reg;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    // ********************
    // instruction word
    // ********************
    // same 32 bits seen as r-type fields or as a u-type immediate
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            rv32i_reg   rs2;
            rv32i_reg   rs1;
            logic [2:0] funct3;
            rv32i_reg   rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [19:0] imm;
            rv32i_reg    rd;
            logic [6:0]  opcode;
        } u;
    } rv32i_instr_t;

    // writeback source
    typedef enum logic [1:0] {
        alu_out   = 2'd0,
        u_imm     = 2'd1,
        mem_rdata = 2'd2
    } regfilemux_sel_t;

    typedef struct packed {
        rv32i_opcode     opcode;
        regfilemux_sel_t regfilemux_sel;
        logic            load_regfile;
    } rv32i_control_word;

    // one pipeline stage, all zero for a bubble
    typedef struct packed {
        rv32i_reg          rs1;
        rv32i_reg          rs2;
        rv32i_reg          rd;
        rv32i_control_word ctrl;
        rv32i_word         u_imm;
    } stage_info_t;

    // ********************
    // forwarding selects
    // ********************
    // alu operands a and b
    typedef enum logic [2:0] {
        id_ex        = 3'd0,
        ex_mem       = 3'd1,
        mem_wb       = 3'd2,
        u_imm_ex_mem = 3'd3,
        u_imm_mem_wb = 3'd4
    } forwarding1_sel_t;

    // store write data
    typedef enum logic {
        mem = 1'b0,
        wb  = 1'b1
    } forwarding2_sel_t;

    // branch compare inputs in decode
    typedef enum logic [2:0] {
        id      = 3'd0,
        ex      = 3'd1,
        mem_alu = 3'd2,
        mem_ld  = 3'd3,
        wb_alu  = 3'd4,
        wb_ld   = 3'd5
    } forwarding3_sel_t;

    typedef struct packed {
        forwarding1_sel_t a;
        forwarding1_sel_t b;
        forwarding2_sel_t c;
        forwarding3_sel_t d;
        forwarding3_sel_t e;
    } fwd_sel_t;

    // ********************
    // datapath values
    // ********************
    typedef struct packed {
        rv32i_word id_ex_rs1;
        rv32i_word id_ex_rs2;
        rv32i_word ex_mem_rs2;
        rv32i_word regfile_rs1;
        rv32i_word regfile_rs2;
        rv32i_word ex_result;
        rv32i_word mem_alu;
        rv32i_word mem_ld;
        rv32i_word wb_data;
    } stage_data_t;

    typedef struct packed {
        rv32i_word alu_a;
        rv32i_word alu_b;
        rv32i_word store_data;
        rv32i_word branch_a;
        rv32i_word branch_b;
    } operands_t;

endpackage

//--- hw/hazard_cfg.svh
`ifndef HAZARD_CFG_SVH
`define HAZARD_CFG_SVH

// datapath word width
`define HAZ_XLEN 32

// register index width, 32 architectural regs
`define HAZ_REG_W 5

// bubble cycles inserted per load-use hazard
`define HAZ_STALL_LEN 1

`endif
